//--- mcu_params.svh
// Global defines for the memory subsystem: bus widths, master and credit
// counts, RAM size and timer peripheral addresses
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// bus field widths
`define MCU_ADDR_W   32
`define MCU_DATA_W   32
`define MCU_BE_W     4
`define MCU_MID_W    2
`define MCU_IRQ_ID_W 5

// masters: instruction fetch, data, debug
`define MCU_NUM_MASTERS 3
// credits per master, also the request FIFO depth
`define MCU_CREDITS     2

// two banks, half each
`define MCU_RAM_BYTES 8192

`define MCU_TIMER_MASK_ADDR 32'h1500_0000
`define MCU_TIMER_CNT_ADDR  32'h1500_0004
`define MCU_TIMER_RD_ADDR   32'h1500_1000
`define MCU_TIMER_IRQ_ID    7

`endif

//--- mcu_pkg.sv
// Shared types for the memory subsystem: bus field vectors, master index,
// interrupt id and the decoded request region
`default_nettype none

`include "mcu_params.svh"

package mcu_pkg;

  // byte address and data word on the shared bus
  typedef logic [`MCU_ADDR_W-1:0] addr_t;
  typedef logic [`MCU_DATA_W-1:0] data_t;
  typedef logic [`MCU_BE_W-1:0]   be_t;

  // which master a request belongs to
  typedef logic [`MCU_MID_W-1:0] mid_t;

  typedef logic [`MCU_IRQ_ID_W-1:0] irq_id_t;

  // decoded target of a bus request
  typedef enum logic [1:0] {
    REG_RAM0,
    REG_RAM1,
    REG_TIMER,
    REG_ERR
  } region_t;

endpackage

`default_nettype wire

//--- bus_if.sv
// Shared request/response bus between the arbiter and the RAM slave
`timescale 1ns/1ns
`default_nettype none

interface bus_if import mcu_pkg::*; ();

  // request, driven by the arbiter
  logic  req_valid;
  logic  we;
  addr_t addr;
  data_t wdata;
  be_t   be;
  mid_t  id;

  // response, one cycle after req_valid
  logic  rvalid;
  data_t rdata;
  logic  err;
  mid_t  rid;

  modport master (
    output req_valid, we, addr, wdata, be, id,
    input  rvalid, rdata, err, rid
  );

  modport slave (
    input  req_valid, we, addr, wdata, be, id,
    output rvalid, rdata, err, rid
  );

endinterface

`default_nettype wire

//--- sram_bank.sv
// Single-port word memory with byte-enable writes and registered read data
`timescale 1ns/1ns
`default_nettype none

module sram_bank import mcu_pkg::*; #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  data_t                        wdata_i,
  input  be_t                          be_i,
  output data_t                        rdata_o
);

  localparam int NumBytes = $bits(be_t);

  data_t mem [NUM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // one enable per byte lane
        for (int b = 0; b < NumBytes; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- irq_timer.sv
// Timer pseudo-peripheral: interrupt mask, down-counter and the timer
// interrupt line with acknowledge
`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module irq_timer import mcu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    mask_we_i,
  input  logic    cnt_we_i,
  input  data_t   wdata_i,
  input  irq_id_t irq_id_i,
  input  logic    irq_ack_i,
  output data_t   cnt_o,
  output logic    irq_o
);

  data_t mask_q;
  data_t cnt_q;
  logic  irq_q;
  logic  cnt_hold;
  logic  expire;
  logic  ack_hit;

  // no counting in a cycle with a register write
  assign cnt_hold = mask_we_i || cnt_we_i;
  assign expire   = !cnt_hold && (cnt_q == data_t'(1));
  assign ack_hit  = irq_ack_i && (irq_id_i == irq_id_t'(`MCU_TIMER_IRQ_ID));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
      cnt_q  <= '0;
      irq_q  <= 1'b0;
    end else begin
      if (mask_we_i) begin
        mask_q <= wdata_i;
      end

      if (cnt_we_i) begin
        cnt_q <= wdata_i;
      end else if (!cnt_hold && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end

      // a fresh expiry wins over a same-cycle ack
      if (expire && mask_q[`MCU_TIMER_IRQ_ID]) begin
        irq_q <= 1'b1;
      end else if (ack_hit) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign cnt_o = cnt_q;
  assign irq_o = irq_q;

endmodule

`default_nettype wire

//--- mm_ram.sv
// Bus slave: address decode to two SRAM banks, the timer or an error
// response, with the response registered one cycle after the request
`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module mm_ram import mcu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  bus_if.slave    bus,
  input  irq_id_t irq_id_i,
  input  logic    irq_ack_i,
  output logic    irq_timer_o
);

  localparam int BankWords = `MCU_RAM_BYTES / 8;
  localparam int IdxW      = $clog2(BankWords);
  // lowest address bit above one bank
  localparam int BankBit   = IdxW + 2;

  region_t         region;
  region_t         region_q;
  logic            ram0_req;
  logic            ram1_req;
  logic            mask_we;
  logic            cnt_we;
  logic [IdxW-1:0] word_idx;
  data_t           ram0_rdata;
  data_t           ram1_rdata;
  data_t           timer_cnt;
  data_t           timer_rd_q;

  // timer is write-only at the first two addresses, read-only at the third
  always_comb begin
    region = REG_ERR;
    if (bus.addr < addr_t'(`MCU_RAM_BYTES)) begin
      region = bus.addr[BankBit] ? REG_RAM1 : REG_RAM0;
    end else if (bus.we && (bus.addr == `MCU_TIMER_MASK_ADDR ||
                            bus.addr == `MCU_TIMER_CNT_ADDR)) begin
      region = REG_TIMER;
    end else if (!bus.we && bus.addr == `MCU_TIMER_RD_ADDR) begin
      region = REG_TIMER;
    end
  end

  assign word_idx = bus.addr[BankBit-1:2];
  assign ram0_req = bus.req_valid && (region == REG_RAM0);
  assign ram1_req = bus.req_valid && (region == REG_RAM1);
  assign mask_we  = bus.req_valid && bus.we && (bus.addr == `MCU_TIMER_MASK_ADDR);
  assign cnt_we   = bus.req_valid && bus.we && (bus.addr == `MCU_TIMER_CNT_ADDR);

  sram_bank #(
    .NUM_WORDS(BankWords)
  ) u_ram0 (
    .clk_i  (clk_i),
    .req_i  (ram0_req),
    .we_i   (bus.we),
    .addr_i (word_idx),
    .wdata_i(bus.wdata),
    .be_i   (bus.be),
    .rdata_o(ram0_rdata)
  );

  sram_bank #(
    .NUM_WORDS(BankWords)
  ) u_ram1 (
    .clk_i  (clk_i),
    .req_i  (ram1_req),
    .we_i   (bus.we),
    .addr_i (word_idx),
    .wdata_i(bus.wdata),
    .be_i   (bus.be),
    .rdata_o(ram1_rdata)
  );

  irq_timer u_timer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .mask_we_i(mask_we),
    .cnt_we_i (cnt_we),
    .wdata_i  (bus.wdata),
    .irq_id_i (irq_id_i),
    .irq_ack_i(irq_ack_i),
    .cnt_o    (timer_cnt),
    .irq_o    (irq_timer_o)
  );

  // idle region reads as zero until the first request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus.rvalid <= 1'b0;
      region_q   <= REG_ERR;
      bus.rid    <= '0;
    end else begin
      bus.rvalid <= bus.req_valid;
      if (bus.req_valid) begin
        region_q <= region;
        bus.rid  <= bus.id;
      end
    end
  end

  // count sampled at request time, lines up with the bank read latency
  always_ff @(posedge clk_i) begin
    if (bus.req_valid) begin
      timer_rd_q <= timer_cnt;
    end
  end

  always_comb begin
    case (region_q)
      REG_RAM0:  bus.rdata = ram0_rdata;
      REG_RAM1:  bus.rdata = ram1_rdata;
      REG_TIMER: bus.rdata = timer_rd_q;
      default:   bus.rdata = '0;
    endcase
    bus.err = (region_q == REG_ERR);
  end

endmodule

`default_nettype wire

//--- bus_arbiter.sv
// Per-master credit FIFOs, round-robin grant onto the shared bus and
// response steering back to the issuing master
`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module bus_arbiter import mcu_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic  [`MCU_NUM_MASTERS-1:0]       m_req_valid_i,
  input  logic  [`MCU_NUM_MASTERS-1:0]       m_we_i,
  input  addr_t [`MCU_NUM_MASTERS-1:0]       m_addr_i,
  input  data_t [`MCU_NUM_MASTERS-1:0]       m_wdata_i,
  input  be_t   [`MCU_NUM_MASTERS-1:0]       m_be_i,
  output logic  [`MCU_NUM_MASTERS-1:0]       m_credit_o,
  output logic  [`MCU_NUM_MASTERS-1:0]       m_rvalid_o,
  output data_t [`MCU_NUM_MASTERS-1:0]       m_rdata_o,
  output logic  [`MCU_NUM_MASTERS-1:0]       m_err_o,
  bus_if.master                              bus
);

  localparam int NumM  = `MCU_NUM_MASTERS;
  localparam int Depth = `MCU_CREDITS;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  logic  [NumM-1:0] fifo_empty;
  logic  [NumM-1:0] fifo_pop;
  logic  [NumM-1:0] head_we;
  addr_t [NumM-1:0] head_addr;
  data_t [NumM-1:0] head_wdata;
  be_t   [NumM-1:0] head_be;

  mid_t last_q;
  mid_t grant_idx;
  logic grant_valid;

  // one FIFO per master, a push never finds it full while credits hold
  for (genvar m = 0; m < NumM; m++) begin : g_fifo
    logic            we_mem    [Depth];
    addr_t           addr_mem  [Depth];
    data_t           wdata_mem [Depth];
    be_t             be_mem    [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (m_req_valid_i[m]) begin
          wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (fifo_pop[m]) begin
          rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        case ({m_req_valid_i[m], fifo_pop[m]})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (m_req_valid_i[m]) begin
        we_mem[wr_ptr_q]    <= m_we_i[m];
        addr_mem[wr_ptr_q]  <= m_addr_i[m];
        wdata_mem[wr_ptr_q] <= m_wdata_i[m];
        be_mem[wr_ptr_q]    <= m_be_i[m];
      end
    end

    assign fifo_empty[m] = (cnt_q == '0);
    assign fifo_pop[m]   = grant_valid && (grant_idx == mid_t'(m));
    assign head_we[m]    = we_mem[rd_ptr_q];
    assign head_addr[m]  = addr_mem[rd_ptr_q];
    assign head_wdata[m] = wdata_mem[rd_ptr_q];
    assign head_be[m]    = be_mem[rd_ptr_q];
  end

  // search starts one past the last master served
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = last_q;
    for (int k = 1; k <= NumM; k++) begin
      cand = (int'(last_q) + k) % NumM;
      if (!grant_valid && !fifo_empty[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = mid_t'(cand);
      end
    end
  end

  // credit goes back in the same cycle the request shows on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus.req_valid <= 1'b0;
      m_credit_o    <= '0;
      last_q        <= mid_t'(NumM - 1);
    end else begin
      bus.req_valid <= grant_valid;
      m_credit_o    <= fifo_pop;
      if (grant_valid) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_valid) begin
      bus.we    <= head_we[grant_idx];
      bus.addr  <= head_addr[grant_idx];
      bus.wdata <= head_wdata[grant_idx];
      bus.be    <= head_be[grant_idx];
      bus.id    <= grant_idx;
    end
  end

  // responses go straight through, steered by rid
  always_comb begin
    for (int m = 0; m < NumM; m++) begin
      m_rvalid_o[m] = bus.rvalid && (bus.rid == mid_t'(m));
      m_err_o[m]    = m_rvalid_o[m] && bus.err;
      m_rdata_o[m]  = bus.rdata;
    end
  end

endmodule

`default_nettype wire

//--- mem_subsys_top.sv
// Memory subsystem top: per-master plain ports, shared bus, arbiter and
// RAM slave with the timer interrupt
`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module mem_subsys_top import mcu_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // request side, one entry per master
  input  logic  [`MCU_NUM_MASTERS-1:0] m_req_valid_i,
  input  logic  [`MCU_NUM_MASTERS-1:0] m_we_i,
  input  addr_t [`MCU_NUM_MASTERS-1:0] m_addr_i,
  input  data_t [`MCU_NUM_MASTERS-1:0] m_wdata_i,
  input  be_t   [`MCU_NUM_MASTERS-1:0] m_be_i,
  output logic  [`MCU_NUM_MASTERS-1:0] m_credit_o,
  // response side, must be taken in the cycle it appears
  output logic  [`MCU_NUM_MASTERS-1:0] m_rvalid_o,
  output data_t [`MCU_NUM_MASTERS-1:0] m_rdata_o,
  output logic  [`MCU_NUM_MASTERS-1:0] m_err_o,
  input  irq_id_t                      irq_id_i,
  input  logic                         irq_ack_i,
  output logic                         irq_timer_o
);

  bus_if bus0 ();

  bus_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .m_req_valid_i(m_req_valid_i),
    .m_we_i       (m_we_i),
    .m_addr_i     (m_addr_i),
    .m_wdata_i    (m_wdata_i),
    .m_be_i       (m_be_i),
    .m_credit_o   (m_credit_o),
    .m_rvalid_o   (m_rvalid_o),
    .m_rdata_o    (m_rdata_o),
    .m_err_o      (m_err_o),
    .bus          (bus0.master)
  );

  mm_ram u_mm_ram (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus        (bus0.slave),
    .irq_id_i   (irq_id_i),
    .irq_ack_i  (irq_ack_i),
    .irq_timer_o(irq_timer_o)
  );

endmodule

`default_nettype wire

//--- mem_subsys_properties.sv
// Bound assertions on the credit bound, bus request and response timing
// and outputs held inactive in reset
`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module mem_subsys_properties import mcu_pkg::*; (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic [`MCU_NUM_MASTERS-1:0]  m_req_valid_i,
  input logic [`MCU_NUM_MASTERS-1:0]  m_credit_i,
  input logic [`MCU_NUM_MASTERS-1:0]  m_rvalid_i,
  input logic                         irq_timer_i,
  input logic                         req_valid_i,
  input mid_t                         id_i
);

  localparam int NumM = `MCU_NUM_MASTERS;

  // requests a master has sent without a credit back yet
  int outstanding_q [NumM];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int m = 0; m < NumM; m++) begin
        outstanding_q[m] <= 0;
      end
    end else begin
      for (int m = 0; m < NumM; m++) begin
        outstanding_q[m] <= outstanding_q[m] + int'(m_req_valid_i[m])
                            - int'(m_credit_i[m]);
      end
    end
  end

  for (genvar m = 0; m < NumM; m++) begin : g_credit
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      outstanding_q[m] >= 0 && outstanding_q[m] <= `MCU_CREDITS)
      else $error("master %0d has more requests in flight than credits", m);
  end

  a_req_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(req_valid_i))
    else $error("bus req_valid is unknown");

  // a bus request comes back to the master that sent it one cycle later
  a_resp_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_rvalid_i == ($past(req_valid_i) ? (NumM'(1) << $past(id_i)) : NumM'(0)))
    else $error("bus response did not reach its master one cycle after the request");

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> (m_credit_i == '0 && m_rvalid_i == '0 && !req_valid_i && !irq_timer_i))
    else $error("an output is active during reset");

endmodule

bind mem_subsys_top mem_subsys_properties u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .m_req_valid_i(m_req_valid_i),
  .m_credit_i   (m_credit_o),
  .m_rvalid_i   (m_rvalid_o),
  .irq_timer_i  (irq_timer_o),
  .req_valid_i  (bus0.req_valid),
  .id_i         (bus0.id)
);

`default_nettype wire

//--- tb_mem_subsys.sv
// Testbench for the memory subsystem with credit-tracked stimulus on
// three masters, a shadow memory reference model and response checks
`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module tb_mem_subsys import mcu_pkg::*; ();

  localparam int NumM      = `MCU_NUM_MASTERS;
  localparam int RamWords  = `MCU_RAM_BYTES / 4;
  localparam int AddrHi    = $clog2(RamWords) + 1;
  localparam int WaitLimit = 200;
  // expected-response modes
  localparam logic [1:0] ChkNone  = 2'd0;
  localparam logic [1:0] ChkExact = 2'd1;
  localparam logic [1:0] ChkRange = 2'd2;

  logic             clk_i;
  logic             rst_ni;
  logic  [NumM-1:0] m_req_valid;
  logic  [NumM-1:0] m_we;
  addr_t [NumM-1:0] m_addr;
  data_t [NumM-1:0] m_wdata;
  be_t   [NumM-1:0] m_be;
  logic  [NumM-1:0] m_credit;
  logic  [NumM-1:0] m_rvalid;
  data_t [NumM-1:0] m_rdata;
  logic  [NumM-1:0] m_err;
  irq_id_t          irq_id;
  logic             irq_ack;
  logic             irq_timer;

  int    seed = 82;
  int    err_count;
  int    check_count;
  int    issued;
  int    returned;
  int    credits [NumM];
  data_t shadow [RamWords];
  data_t cnt_written;
  // {mode, err, data} for each request in flight
  logic [34:0] exp_q [NumM][$];

  mem_subsys_top dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .m_req_valid_i(m_req_valid),
    .m_we_i       (m_we),
    .m_addr_i     (m_addr),
    .m_wdata_i    (m_wdata),
    .m_be_i       (m_be),
    .m_credit_o   (m_credit),
    .m_rvalid_o   (m_rvalid),
    .m_rdata_o    (m_rdata),
    .m_err_o      (m_err),
    .irq_id_i     (irq_id),
    .irq_ack_i    (irq_ack),
    .irq_timer_o  (irq_timer)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // expected response from the address map with the shadow memory kept in step
  function automatic logic [34:0] ref_access(input logic we, input addr_t addr,
                                             input data_t wdata, input be_t be);
    int    w;
    data_t word;
    w = int'(addr[AddrHi:2]);
    if (addr < addr_t'(`MCU_RAM_BYTES)) begin
      if (!we) begin
        return {ChkExact, 1'b0, shadow[w]};
      end
      word = shadow[w];
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          word[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      shadow[w] = word;
      return {ChkNone, 1'b0, 32'h0};
    end
    if (we && addr == `MCU_TIMER_MASK_ADDR) begin
      return {ChkNone, 1'b0, 32'h0};
    end
    if (we && addr == `MCU_TIMER_CNT_ADDR) begin
      cnt_written = wdata;
      return {ChkNone, 1'b0, 32'h0};
    end
    // running count lies between 1 and the loaded value
    if (!we && addr == `MCU_TIMER_RD_ADDR) begin
      return {ChkRange, 1'b0, cnt_written};
    end
    return {ChkExact, 1'b1, 32'h0};
  endfunction

  function automatic data_t fill_word(input addr_t addr);
    return (data_t'(addr) * 32'h9e37_79b9) ^ 32'h0f0f_a5a5;
  endfunction

  // word in a master's own slice of either bank
  function automatic addr_t ram_addr(input int m);
    int r;
    r = $random(seed);
    return addr_t'(((r & 1) * 1024 + m * 256 + ((r >> 1) & 255)) * 4);
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int m = 0; m < NumM; m++) begin
      n += exp_q[m].size();
    end
    return n;
  endfunction

  task automatic check_val(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("*** FAILED ***");
    $finish;
  endtask

  // called and returns at a falling edge
  task automatic issue(input int m, input logic we, input addr_t addr,
                       input data_t wdata, input be_t be);
    int waited;
    waited = 0;
    while (credits[m] == 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) begin
        abort_run($sformatf("no credit came back to master %0d", m));
      end
    end
    m_req_valid[m] = 1'b1;
    m_we[m]        = we;
    m_addr[m]      = addr;
    m_wdata[m]     = wdata;
    m_be[m]        = be;
    credits[m]--;
    issued++;
    exp_q[m].push_back(ref_access(we, addr, wdata, be));
    @(negedge clk_i);
    m_req_valid[m] = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) begin
        abort_run($sformatf("%0d responses never arrived", pending()));
      end
    end
  endtask

  task automatic traffic(input int m);
    addr_t a;
    for (int i = 0; i < 40; i++) begin
      a = ram_addr(m);
      issue(m, 1'($random(seed)), a, data_t'($random(seed)), be_t'($random(seed)));
    end
  endtask

  task automatic wait_irq(input logic level, input int limit, input string what);
    int waited;
    waited = 0;
    while (irq_timer !== level) begin
      @(negedge clk_i);
      waited++;
      if (waited > limit) begin
        abort_run(what);
      end
    end
  endtask

  task automatic pulse_ack(input irq_id_t id);
    irq_id  = id;
    irq_ack = 1'b1;
    @(negedge clk_i);
    irq_ack = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // outputs sampled at the rising edge before the DUT updates them
  always @(posedge clk_i) begin
    logic [34:0] e;
    if (rst_ni) begin
      for (int m = 0; m < NumM; m++) begin
        if (m_credit[m]) begin
          credits[m]++;
          returned++;
        end
        if (m_rvalid[m]) begin
          if (exp_q[m].size() == 0) begin
            err_count++;
            $display("master %0d got a response with nothing in flight at %0t", m, $time);
          end else begin
            e = exp_q[m].pop_front();
            check_val($sformatf("m_err_o[%0d]", m), data_t'(m_err[m]), data_t'(e[32]));
            if (e[34:33] == ChkExact) begin
              check_val($sformatf("m_rdata_o[%0d]", m), m_rdata[m], e[31:0]);
            end else if (e[34:33] == ChkRange) begin
              check_count++;
              if (m_rdata[m] == '0 || m_rdata[m] > e[31:0]) begin
                err_count++;
                $display("[ERROR] t=%0t m_rdata_o[%0d]: got %0d, expected 1 to %0d",
                         $time, m, m_rdata[m], e[31:0]);
              end
            end
          end
        end
      end
    end
  end

  initial begin
    int    e0;
    addr_t a;
    addr_t wa [32];
    m_req_valid = '0;
    m_we        = '0;
    m_addr      = '0;
    m_wdata     = '0;
    m_be        = '0;
    irq_id      = '0;
    irq_ack     = 1'b0;
    rst_ni      = 1'b0;
    err_count   = 0;
    check_count = 0;
    issued      = 0;
    returned    = 0;
    cnt_written = '0;
    for (int m = 0; m < NumM; m++) begin
      credits[m] = `MCU_CREDITS;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // preload both banks, then byte-enable writes and read back
    e0 = err_count;
    for (int w = 0; w < RamWords; w++) begin
      a = addr_t'(w * 4);
      issue(1, 1'b1, a, fill_word(a), 4'hf);
    end
    for (int i = 0; i < 32; i++) begin
      wa[i] = ram_addr(1);
      issue(1, 1'b1, wa[i], data_t'($random(seed)), be_t'($random(seed)));
    end
    for (int i = 0; i < 32; i++) begin
      issue(1, 1'b0, wa[i], '0, '0);
    end
    drain();
    report_test("test 1 byte-enable writes", e0);

    e0 = err_count;
    fork
      traffic(0);
      traffic(1);
      traffic(2);
    join
    drain();
    check_val("credits returned", data_t'(returned), data_t'(issued));
    for (int m = 0; m < NumM; m++) begin
      check_val($sformatf("credits[%0d]", m), data_t'(credits[m]), `MCU_CREDITS);
    end
    report_test("test 2 concurrent masters", e0);

    // unmapped accesses, then the RAM words they would alias
    e0 = err_count;
    for (int i = 0; i < 8; i++) begin
      a = addr_t'($random(seed)) | 32'h2000_0000;
      issue(i % NumM, 1'b1, a, data_t'($random(seed)), 4'hf);
      issue(i % NumM, 1'b0, a, '0, '0);
      issue(1, 1'b0, a & 32'h0000_1ffc, '0, '0);
    end
    issue(0, 1'b1, 32'h0000_2000, 32'hdead_beef, 4'hf);
    issue(0, 1'b0, 32'h0000_0000, '0, '0);
    issue(2, 1'b0, 32'h1500_0008, '0, '0);
    issue(0, 1'b0, `MCU_TIMER_MASK_ADDR, '0, '0);
    issue(2, 1'b1, `MCU_TIMER_RD_ADDR, 32'h1, 4'hf);
    drain();
    report_test("test 3 unmapped addresses", e0);

    e0 = err_count;
    issue(1, 1'b1, `MCU_TIMER_MASK_ADDR, 32'h1 << `MCU_TIMER_IRQ_ID, 4'hf);
    issue(1, 1'b1, `MCU_TIMER_CNT_ADDR, 32'd20, 4'hf);
    issue(1, 1'b0, `MCU_TIMER_RD_ADDR, '0, '0);
    drain();
    check_val("irq_timer_o", data_t'(irq_timer), '0);
    wait_irq(1'b1, 40, "timer interrupt did not rise within 40 cycles");
    report_test("test 4 timer interrupt", e0);

    e0 = err_count;
    pulse_ack(irq_id_t'(3));
    check_val("irq_timer_o", data_t'(irq_timer), 32'h1);
    pulse_ack(irq_id_t'(`MCU_TIMER_IRQ_ID));
    check_val("irq_timer_o", data_t'(irq_timer), '0);
    issue(1, 1'b1, `MCU_TIMER_MASK_ADDR, '0, 4'hf);
    issue(1, 1'b1, `MCU_TIMER_CNT_ADDR, 32'd10, 4'hf);
    drain();
    // masked expiry stays quiet
    for (int i = 0; i < 30; i++) begin
      @(negedge clk_i);
      check_val("irq_timer_o", data_t'(irq_timer), '0);
    end
    report_test("test 5 timer acknowledge and mask", e0);

    $display("checks: %0d, errors: %0d, requests: %0d", check_count, err_count, issued);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
mcu_pkg.sv
bus_if.sv
sram_bank.sv
irq_timer.sv
mm_ram.sv
bus_arbiter.sv
mem_subsys_top.sv
mem_subsys_properties.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the memory subsystem testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsys -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1
